//--- Makefile
# Verilator build and run of the write buffer testbench

VERILATOR ?= verilator
TOP       ?= wbuf_tb
FILELIST  ?= files.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^RESULT: PASS$$" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
+incdir+source
source/wbuf_pkg.sv
source/wbuf_write_ctrl.sv
source/wbuf_slots.sv
source/wbuf_send_ctrl.sv
source/wbuf_top.sv
tests/wbuf_asserts.sv
tests/wbuf_tb.sv

//--- source/wbuf_consts.svh
/*
 * Sizing constants of the coalescing write buffer.
 * Slot count, address and word widths, line geometry and age counter width.
 */
`ifndef WBUF_CONSTS_SVH
`define WBUF_CONSTS_SVH

// Number of line slots
`define WBUF_ENTRIES 4

// Physical address width in bits
`define WBUF_PA_W 32

// Width of one write word
`define WBUF_WORD_W 32

// Words held by one line
`define WBUF_WORDS 4

// Width of the per-slot age counter
`define WBUF_TIMECNT_W 4

// Byte offset bits inside a line (16 bytes)
`define WBUF_OFFSET_W 4

// Byte offset bits inside a word
`define WBUF_WORD_OFFSET_W 2

// Line tag is what is left above the line offset
`define WBUF_TAG_W (`WBUF_PA_W - `WBUF_OFFSET_W)

`endif

//--- source/wbuf_pkg.sv
/*
 * Shared types of the write buffer.
 * Slot state enum, index, tag, line and mask types, and the packed structs
 * passed between the write controller, the slot store and the send engine.
 */
`include "wbuf_consts.svh"

package wbuf_pkg;

    typedef enum logic [1:0] {
        WBUF_FREE   = 2'b00,
        WBUF_OPEN   = 2'b01,
        WBUF_CLOSED = 2'b10,
        WBUF_SENT   = 2'b11
    } wbuf_state_e;

    typedef logic [$clog2(`WBUF_ENTRIES)-1:0]                  wbuf_idx_t;
    typedef logic [`WBUF_TAG_W-1:0]                            wbuf_tag_t;
    typedef logic [`WBUF_WORDS-1:0][`WBUF_WORD_W-1:0]          wbuf_line_t;
    typedef logic [`WBUF_WORDS-1:0][`WBUF_WORD_W/8-1:0]        wbuf_line_be_t;
    typedef logic [`WBUF_TIMECNT_W-1:0]                        wbuf_timecnt_t;

    // Request seen at the write port
    typedef struct packed {
        logic [`WBUF_PA_W-1:0]     addr;
        logic [`WBUF_WORD_W-1:0]   data;
        logic [`WBUF_WORD_W/8-1:0] be;
    } wbuf_write_req_t;

    // Command from the write controller into the slot store
    typedef struct packed {
        logic          alloc;
        logic          merge;
        wbuf_idx_t     idx;
        wbuf_tag_t     tag;
        wbuf_line_t    line;
        wbuf_line_be_t be;
    } wbuf_write_cmd_t;

    // States and tags of every slot
    typedef struct packed {
        wbuf_state_e [`WBUF_ENTRIES-1:0] state;
        wbuf_tag_t   [`WBUF_ENTRIES-1:0] tag;
    } wbuf_slot_view_t;

    // One line request towards memory
    typedef struct packed {
        logic [`WBUF_PA_W-1:0] addr;
        wbuf_idx_t             id;
        wbuf_line_t            line;
        wbuf_line_be_t         be;
    } wbuf_send_t;

endpackage

//--- source/wbuf_send_ctrl.sv
/*
 * Send engine of the write buffer.
 * Round-robin pick of closed slots and the registered send channel.
 */
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_send_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  wbuf_pkg::wbuf_slot_view_t view_i,
    input  wbuf_pkg::wbuf_line_t      rd_line_i,
    input  wbuf_pkg::wbuf_line_be_t   rd_be_i,
    input  logic                      send_ready_i,
    output logic                      take_o,
    output wbuf_pkg::wbuf_idx_t       take_idx_o,
    output logic                      send_valid_o,
    output wbuf_pkg::wbuf_send_t      send_o
);
    import wbuf_pkg::*;

    wbuf_idx_t  rr_ptr_q;
    logic       valid_q;
    wbuf_send_t send_q;
    logic       can_load;
    logic       found;
    wbuf_idx_t  pick;

    // Register is empty or drains this cycle
    assign can_load = !valid_q || send_ready_i;

    // First closed slot after the last one taken
    always_comb begin
        found = 1'b0;
        pick  = rr_ptr_q;
        for (int i = 1; i <= `WBUF_ENTRIES; i++) begin
            if (!found &&
                (view_i.state[(int'(rr_ptr_q) + i) % `WBUF_ENTRIES] == WBUF_CLOSED)) begin
                found = 1'b1;
                pick  = wbuf_idx_t'((int'(rr_ptr_q) + i) % `WBUF_ENTRIES);
            end
        end
    end

    assign take_o     = can_load & found;
    assign take_idx_o = pick;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_ptr_q <= '0;
            valid_q  <= 1'b0;
        end else if (take_o) begin
            rr_ptr_q <= pick;
            valid_q  <= 1'b1;
        end else if (send_ready_i) begin
            valid_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            send_q.addr <= {view_i.tag[pick], {`WBUF_OFFSET_W{1'b0}}};
            send_q.id   <= pick;
            send_q.line <= rd_line_i;
            send_q.be   <= rd_be_i;
        end
    end

    assign send_valid_o = valid_q;
    assign send_o       = send_q;

endmodule

//--- source/wbuf_slots.sv
/*
 * Slot store of the write buffer.
 * Per-slot state, tag, age counter, line data and byte mask, with the
 * read port for the send engine and the empty and full flags.
 */
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_slots (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  wbuf_pkg::wbuf_write_cmd_t cmd_i,
    input  logic                      close_new_i,
    input  wbuf_pkg::wbuf_timecnt_t   cfg_threshold_i,
    input  logic                      take_i,
    input  wbuf_pkg::wbuf_idx_t       take_idx_i,
    input  logic                      ack_i,
    input  wbuf_pkg::wbuf_idx_t       ack_id_i,
    output wbuf_pkg::wbuf_slot_view_t view_o,
    output wbuf_pkg::wbuf_line_t      rd_line_o,
    output wbuf_pkg::wbuf_line_be_t   rd_be_o,
    output logic                      empty_o,
    output logic                      full_o
);
    import wbuf_pkg::*;

    wbuf_state_e [`WBUF_ENTRIES-1:0] state_q;
    wbuf_tag_t   [`WBUF_ENTRIES-1:0] tag_q;
    wbuf_timecnt_t                   age_q  [`WBUF_ENTRIES];
    wbuf_line_t                      line_q [`WBUF_ENTRIES];
    wbuf_line_be_t                   be_q   [`WBUF_ENTRIES];
    wbuf_timecnt_t                   close_age;

    // Enabled bytes of the new line replace the old ones
    function automatic wbuf_line_t merge_line(
        input wbuf_line_t    old_line,
        input wbuf_line_t    new_line,
        input wbuf_line_be_t new_be
    );
        wbuf_line_t ret;
        for (int w = 0; w < `WBUF_WORDS; w++) begin
            for (int b = 0; b < `WBUF_WORD_W/8; b++) begin
                ret[w][b*8 +: 8] = new_be[w][b] ? new_line[w][b*8 +: 8]
                                                : old_line[w][b*8 +: 8];
            end
        end
        return ret;
    endfunction

    // Age value at which an open slot closes
    assign close_age = cfg_threshold_i - 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `WBUF_ENTRIES; i++) begin
                state_q[i] <= WBUF_FREE;
                age_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < `WBUF_ENTRIES; i++) begin
                case (state_q[i])
                    WBUF_FREE: begin
                        if (cmd_i.alloc && (cmd_i.idx == wbuf_idx_t'(i))) begin
                            state_q[i] <= close_new_i ? WBUF_CLOSED : WBUF_OPEN;
                            age_q[i]   <= '0;
                        end
                    end
                    WBUF_OPEN: begin
                        age_q[i] <= age_q[i] + 1'b1;
                        if (age_q[i] == close_age) begin
                            state_q[i] <= WBUF_CLOSED;
                        end
                    end
                    WBUF_CLOSED: begin
                        if (take_i && (take_idx_i == wbuf_idx_t'(i))) begin
                            state_q[i] <= WBUF_SENT;
                        end
                    end
                    default: begin
                        if (ack_i && (ack_id_i == wbuf_idx_t'(i))) begin
                            state_q[i] <= WBUF_FREE;
                        end
                    end
                endcase
            end
        end
    end

    // Line storage, written on alloc and merge
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `WBUF_ENTRIES; i++) begin
            if (cmd_i.alloc && (cmd_i.idx == wbuf_idx_t'(i))) begin
                tag_q[i]  <= cmd_i.tag;
                line_q[i] <= merge_line('0, cmd_i.line, cmd_i.be);
                be_q[i]   <= cmd_i.be;
            end else if (cmd_i.merge && (cmd_i.idx == wbuf_idx_t'(i))) begin
                line_q[i] <= merge_line(line_q[i], cmd_i.line, cmd_i.be);
                be_q[i]   <= be_q[i] | cmd_i.be;
            end
        end
    end

    assign view_o.state = state_q;
    assign view_o.tag   = tag_q;

    // Read port for the slot being taken
    assign rd_line_o = line_q[take_idx_i];
    assign rd_be_o   = be_q[take_idx_i];

    always_comb begin
        empty_o = 1'b1;
        full_o  = 1'b1;
        for (int i = 0; i < `WBUF_ENTRIES; i++) begin
            empty_o &= (state_q[i] == WBUF_FREE);
            full_o  &= (state_q[i] != WBUF_FREE);
        end
    end

endmodule

//--- source/wbuf_top.sv
/*
 * Top level of the coalescing write buffer.
 * Write controller, slot store and send engine.
 */
`timescale 1ns/1ps

module wbuf_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  wbuf_pkg::wbuf_timecnt_t   cfg_threshold_i,
    input  logic                      write_i,
    input  wbuf_pkg::wbuf_write_req_t write_req_i,
    output logic                      write_ready_o,
    output logic                      send_valid_o,
    input  logic                      send_ready_i,
    output wbuf_pkg::wbuf_send_t      send_o,
    input  logic                      ack_i,
    input  wbuf_pkg::wbuf_idx_t       ack_id_i,
    output logic                      empty_o,
    output logic                      full_o
);
    import wbuf_pkg::*;

    wbuf_slot_view_t view;
    wbuf_write_cmd_t cmd;
    logic            close_new;
    logic            take;
    wbuf_idx_t       take_idx;
    wbuf_line_t      rd_line;
    wbuf_line_be_t   rd_be;

    wbuf_write_ctrl write_ctrl_i (
        .write_i         (write_i),
        .write_req_i     (write_req_i),
        .cfg_threshold_i (cfg_threshold_i),
        .view_i          (view),
        .write_ready_o   (write_ready_o),
        .cmd_o           (cmd),
        .close_new_o     (close_new)
    );

    wbuf_slots slots_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cmd_i           (cmd),
        .close_new_i     (close_new),
        .cfg_threshold_i (cfg_threshold_i),
        .take_i          (take),
        .take_idx_i      (take_idx),
        .ack_i           (ack_i),
        .ack_id_i        (ack_id_i),
        .view_o          (view),
        .rd_line_o       (rd_line),
        .rd_be_o         (rd_be),
        .empty_o         (empty_o),
        .full_o          (full_o)
    );

    wbuf_send_ctrl send_ctrl_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .view_i          (view),
        .rd_line_i       (rd_line),
        .rd_be_i         (rd_be),
        .send_ready_i    (send_ready_i),
        .take_o          (take),
        .take_idx_o      (take_idx),
        .send_valid_o    (send_valid_o),
        .send_o          (send_o)
    );

endmodule

//--- source/wbuf_write_ctrl.sv
/*
 * Write controller of the write buffer.
 * Matches an incoming write against the slots and builds the alloc or
 * merge command, or stalls the write.
 */
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_write_ctrl (
    input  logic                     write_i,
    input  wbuf_pkg::wbuf_write_req_t write_req_i,
    input  wbuf_pkg::wbuf_timecnt_t  cfg_threshold_i,
    input  wbuf_pkg::wbuf_slot_view_t view_i,
    output logic                     write_ready_o,
    output wbuf_pkg::wbuf_write_cmd_t cmd_o,
    output logic                     close_new_o
);
    import wbuf_pkg::*;

    wbuf_tag_t                                      write_tag;
    logic [`WBUF_OFFSET_W-`WBUF_WORD_OFFSET_W-1:0]  word_sel;
    logic                                           hit_open;
    logic                                           hit_closed;
    logic                                           free_found;
    wbuf_idx_t                                      open_idx;
    wbuf_idx_t                                      free_idx;
    logic                                           transfer;

    assign write_tag = write_req_i.addr[`WBUF_PA_W-1:`WBUF_OFFSET_W];
    assign word_sel  = write_req_i.addr[`WBUF_OFFSET_W-1:`WBUF_WORD_OFFSET_W];

    // Same-line hits and the lowest free slot
    always_comb begin
        hit_open   = 1'b0;
        hit_closed = 1'b0;
        free_found = 1'b0;
        open_idx   = '0;
        free_idx   = '0;
        for (int i = 0; i < `WBUF_ENTRIES; i++) begin
            if ((view_i.state[i] == WBUF_OPEN) && (view_i.tag[i] == write_tag)) begin
                hit_open = 1'b1;
                open_idx = wbuf_idx_t'(i);
            end
            if ((view_i.state[i] == WBUF_CLOSED) && (view_i.tag[i] == write_tag)) begin
                hit_closed = 1'b1;
            end
            if ((view_i.state[i] == WBUF_FREE) && !free_found) begin
                free_found = 1'b1;
                free_idx   = wbuf_idx_t'(i);
            end
        end
    end

    // A closed slot of the same line holds the write back to keep order
    assign write_ready_o = hit_open | (!hit_closed & free_found);
    assign transfer      = write_i & write_ready_o;

    always_comb begin
        cmd_o.alloc = transfer & !hit_open;
        cmd_o.merge = transfer & hit_open;
        cmd_o.idx   = hit_open ? open_idx : free_idx;
        cmd_o.tag   = write_tag;
        for (int w = 0; w < `WBUF_WORDS; w++) begin
            cmd_o.line[w] = write_req_i.data;
            cmd_o.be[w]   = (w == int'(word_sel)) ? write_req_i.be : '0;
        end
    end

    // Zero threshold means no coalescing window at all
    assign close_new_o = cmd_o.alloc & (cfg_threshold_i == '0);

endmodule

//--- tests/wbuf_asserts.sv
/*
 * Concurrent protocol checks of the write buffer, bound into the top level.
 * Acknowledge target, send channel stability and flag exclusion.
 */
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_asserts (
    input logic                                       clk_i,
    input logic                                       rst_ni,
    input wbuf_pkg::wbuf_state_e [`WBUF_ENTRIES-1:0]  state_i,
    input logic                                       ack_i,
    input wbuf_pkg::wbuf_idx_t                        ack_id_i,
    input logic                                       send_valid_i,
    input logic                                       send_ready_i,
    input wbuf_pkg::wbuf_send_t                       send_i,
    input logic                                       empty_i,
    input logic                                       full_i
);
    import wbuf_pkg::*;

    // Only a line in flight can be acknowledged
    ack_names_sent: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> (state_i[ack_id_i] == WBUF_SENT))
        else $error("acknowledge for slot %0d which has no line in flight", ack_id_i);

    // Stalled send item holds still
    send_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (send_valid_i && !send_ready_i) |=> (send_valid_i && $stable(send_i)))
        else $error("send item changed or dropped while stalled");

    flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(empty_i && full_i))
        else $error("empty and full flags high together");

endmodule

bind wbuf_top wbuf_asserts asserts_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .state_i      (view.state),
    .ack_i        (ack_i),
    .ack_id_i     (ack_id_i),
    .send_valid_i (send_valid_o),
    .send_ready_i (send_ready_i),
    .send_i       (send_o),
    .empty_i      (empty_o),
    .full_i       (full_o)
);

//--- tests/wbuf_tb.sv
/*
 * Testbench of the coalescing write buffer.
 * Clock and reset, LFSR stimulus, reference line builder, send checker
 * and the directed and random tests.
 */
`timescale 1ns/1ps
`include "wbuf_consts.svh"

module wbuf_tb;
    import wbuf_pkg::*;

    localparam int WAIT_LIMIT   = 2000;
    localparam int WAIT_DRAINED = 0;
    localparam int WAIT_EMPTY   = 1;
    localparam int WAIT_ROOM    = 2;
    localparam int READY_ON     = 0;
    localparam int READY_OFF    = 1;
    localparam int READY_RAND   = 2;
    localparam int RAND_WRITES  = 32;

    logic            clk_i;
    logic            rst_ni;
    wbuf_timecnt_t   cfg_threshold_i;
    logic            write_i;
    wbuf_write_req_t write_req_i;
    logic            write_ready_o;
    logic            send_valid_o;
    logic            send_ready_i;
    wbuf_send_t      send_o;
    logic            ack_i;
    wbuf_idx_t       ack_id_i;
    logic            empty_o;
    logic            full_o;

    wbuf_send_t      exp_q[$];
    wbuf_idx_t       ack_q[$];
    wbuf_write_req_t batch[4];
    int              batch_n = 0;
    int              sends_seen = 0;
    int              send_base = 0;
    int              errors = 0;
    int              ready_mode = READY_ON;
    logic            ack_on = 1'b1;
    logic            ack_rand = 1'b0;
    logic [15:0]     lfsr_state = 16'd41;
    string           cur_test = "reset";

    wbuf_top dut_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cfg_threshold_i (cfg_threshold_i),
        .write_i         (write_i),
        .write_req_i     (write_req_i),
        .write_ready_o   (write_ready_o),
        .send_valid_o    (send_valid_o),
        .send_ready_i    (send_ready_i),
        .send_o          (send_o),
        .ack_i           (ack_i),
        .ack_id_i        (ack_id_i),
        .empty_o         (empty_o),
        .full_o          (full_o)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Expected line for a list of writes to one line, later bytes win
    function automatic wbuf_send_t expect_send(input wbuf_write_req_t wr[4], input int n);
        wbuf_send_t exp;
        logic [1:0] word;
        exp = '0;
        exp.addr = {wr[0].addr[`WBUF_PA_W-1:`WBUF_OFFSET_W], {`WBUF_OFFSET_W{1'b0}}};
        for (int k = 0; k < n; k++) begin
            word = wr[k].addr[3:2];
            for (int b = 0; b < 4; b++) begin
                if (wr[k].be[b]) begin
                    exp.line[word][8*b +: 8] = wr[k].data[8*b +: 8];
                    exp.be[word][b] = 1'b1;
                end
            end
        end
        return exp;
    endfunction

    task automatic abort_run();
        errors++;
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wait_for(input int what, input string desc);
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            cycles++;
            case (what)
                WAIT_DRAINED: done = (exp_q.size() == 0);
                WAIT_EMPTY:   done = empty_o;
                default:      done = !full_o;
            endcase
        end
        if (!done) begin
            $display("timed out waiting for %s in test %s", desc, cur_test);
            abort_run();
        end
    endtask

    // Holds write_i high until the write is taken
    task automatic add_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        write_i = 1'b1;
        write_req_i = '{addr: addr, data: data, be: be};
        batch[batch_n] = write_req_i;
        batch_n++;
        @(posedge clk_i);
        while (!write_ready_o && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!write_ready_o) begin
            $display("write to %h was never accepted in test %s", addr, cur_test);
            abort_run();
        end
    endtask

    task automatic close_batch();
        exp_q.push_back(expect_send(batch, batch_n));
        batch_n = 0;
    endtask

    task automatic write_idle();
        @(negedge clk_i);
        write_i = 1'b0;
    endtask

    task automatic start_test(input string name, input int thr, input int ready,
                              input logic acks, input logic rnd);
        @(posedge clk_i);
        cur_test = name;
        ready_mode = ready;
        ack_on = acks;
        ack_rand = rnd;
        @(negedge clk_i);
        cfg_threshold_i = wbuf_timecnt_t'(thr);
        send_base = sends_seen;
    endtask

    task automatic finish_test(input int expected_sends);
        wait_for(WAIT_DRAINED, "all expected sends");
        wait_for(WAIT_EMPTY, "the buffer to empty");
        check({cur_test, " send count"}, expected_sends, sends_seen - send_base);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Memory side: send ready and acknowledges
    initial begin
        send_ready_i = 1'b0;
        ack_i = 1'b0;
        ack_id_i = '0;
        forever begin
            @(negedge clk_i);
            ack_i = 1'b0;
            case (ready_mode)
                READY_ON:  send_ready_i = 1'b1;
                READY_OFF: send_ready_i = 1'b0;
                default:   send_ready_i = (rand_bits(1) != 0);
            endcase
            if (ack_on && (ack_q.size() > 0) && (!ack_rand || rand_bits(2) == 0)) begin
                ack_i = 1'b1;
                ack_id_i = ack_q.pop_front();
            end
        end
    end

    // Compares every send transfer with the pending item of the same line
    initial begin : compare_sends
        wbuf_send_t got;
        int         hit;
        forever begin
            @(posedge clk_i);
            if (rst_ni && send_valid_o && send_ready_i) begin
                got = send_o;
                hit = -1;
                foreach (exp_q[k]) begin
                    if (hit < 0 && exp_q[k].addr == got.addr) begin
                        hit = k;
                    end
                end
                if (hit < 0) begin
                    $display("unexpected send to line %h in test %s", got.addr, cur_test);
                    abort_run();
                end else begin
                    check({cur_test, " line"}, exp_q[hit].line, got.line);
                    check({cur_test, " mask"}, exp_q[hit].be, got.be);
                    exp_q.delete(hit);
                    ack_q.push_back(got.id);
                    sends_seen++;
                end
            end
        end
    end

    initial begin
        logic [19:0] line_hi;
        logic [1:0]  word_lo;
        logic [31:0] wdata;
        logic [3:0]  wbe;
        rst_ni = 1'b0;
        cfg_threshold_i = '0;
        write_i = 1'b0;
        write_req_i = '0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check("reset empty", 1, empty_o);
        check("reset full", 0, full_o);

        start_test("single", 3, READY_ON, 1'b1, 1'b0);
        add_write(32'h0000_1238, 32'ha1b2_c3d4, 4'b0110);
        write_idle();
        close_batch();
        finish_test(1);

        start_test("coalesce", 15, READY_ON, 1'b1, 1'b0);
        add_write(32'h0000_2000, 32'h1111_2222, 4'b1111);
        add_write(32'h0000_2004, 32'h3333_4444, 4'b0011);
        write_idle();
        close_batch();
        finish_test(1);

        // Second write to the line waits until the first is sent
        start_test("order", 0, READY_ON, 1'b1, 1'b0);
        add_write(32'h0000_3008, 32'haaaa_aaaa, 4'b1111);
        close_batch();
        add_write(32'h0000_3008, 32'h5555_5555, 4'b1001);
        close_batch();
        write_idle();
        finish_test(2);

        start_test("full", 0, READY_OFF, 1'b0, 1'b0);
        for (int k = 0; k < `WBUF_ENTRIES; k++) begin
            add_write(32'h0000_4000 + 32'(k * 16), 32'(k + 1), 4'b1111);
            close_batch();
        end
        @(negedge clk_i);
        write_i = 1'b0;
        write_req_i.addr = 32'h0000_4400;
        @(posedge clk_i);
        check("full flag", 1, full_o);
        check("ready while full", 0, write_ready_o);
        start_test("full", 0, READY_ON, 1'b0, 1'b0);
        wait_for(WAIT_DRAINED, "stalled sends to drain");
        check("full after drain", 1, full_o);
        start_test("full", 0, READY_ON, 1'b1, 1'b0);
        wait_for(WAIT_ROOM, "a slot to be freed");
        add_write(32'h0000_4400, 32'hdead_beef, 4'b1100);
        write_idle();
        close_batch();
        finish_test(1);

        start_test("random", 0, READY_RAND, 1'b1, 1'b1);
        for (int k = 0; k < RAND_WRITES; k++) begin
            line_hi = 20'(rand_bits(20));
            word_lo = 2'(rand_bits(2));
            wdata   = rand_bits(32);
            wbe     = 4'(rand_bits(4));
            add_write({line_hi, 8'(k), word_lo, 2'b00}, wdata, wbe);
            close_batch();
        end
        write_idle();
        finish_test(RAND_WRITES);

        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
